//--- verilog/mem_port_pkg.sv
// Data cache and MMU port widths plus the returned data word, referenced by scoped name
package mem_port_pkg;

  // ---------------------------------------------------------------------------
  // datapath and address widths
  // ---------------------------------------------------------------------------

  // integer register and cache data width
  localparam int unsigned XLEN = 64;
  // one byte enable per byte lane of the data word
  localparam int unsigned BYTE_LANES = XLEN / 8;
  // virtual and physical address widths of an Sv39 system
  localparam int unsigned VLEN = 39;
  localparam int unsigned PLEN = 56;
  // the index is the untranslated page offset, the tag is the rest of the physical address
  localparam int unsigned INDEX_W = 12;
  localparam int unsigned TAG_W = PLEN - INDEX_W;
  // the cache echoes this id with every response so loads can return out of order
  localparam int unsigned REQ_ID_W = 2;

  // the response word is read as one value by the shifter and lane by lane
  // when the sign candidates are picked out
  typedef union packed {
    logic [XLEN-1:0]                 word;
    logic [BYTE_LANES-1:0][7:0]      lanes;
  } rdata_u;

endpackage

//--- verilog/load_pkg.sv
// Load operation codes, load buffer geometry and entry layout, referenced by scoped name
package load_pkg;

  // ---------------------------------------------------------------------------
  // load buffer geometry
  // ---------------------------------------------------------------------------

  // one entry per load that has been granted by the cache and not yet answered
  localparam int unsigned LDBUF_ENTRIES = 4;
  localparam int unsigned LDBUF_IDX_W = 2;
  // width of the scoreboard id that travels with each load
  localparam int unsigned TRANS_ID_W = 3;
  // byte offset of the load inside the 64-bit word
  localparam int unsigned OFFSET_W = 3;

  // integer load flavours, the U variants zero extend
  typedef enum logic [2:0] {
    LD  = 3'd0,
    LW  = 3'd1,
    LWU = 3'd2,
    LH  = 3'd3,
    LHU = 3'd4,
    LB  = 3'd5,
    LBU = 3'd6
  } load_op_e;

  // what must be remembered about a load until its data comes back
  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [OFFSET_W-1:0]   offset;
    load_op_e              op;
  } ldbuf_entry_t;

  // transfer size as log2 of the byte count, as the cache expects it
  function automatic logic [1:0] size_of(load_op_e op);
    logic [1:0] size;
    case (op)
      LW, LWU: size = 2'b10;
      LH, LHU: size = 2'b01;
      LB, LBU: size = 2'b00;
      // doublewords and anything unexpected use the full word
      default: size = 2'b11;
    endcase
    return size;
  endfunction

endpackage

//--- verilog/load_ctrl_fsm.sv
// Load request sequencer, instantiated by the load unit to drive the MMU and cache request strobes
module load_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic valid_i,
  input  logic ldbuf_full_i,
  input  logic page_offset_match_i,
  input  logic data_gnt_i,
  input  logic dtlb_hit_i,
  input  logic ex_valid_i,
  input  logic data_rvalid_i,
  output logic translation_req_o,
  output logic data_req_o,
  output logic tag_valid_o,
  output logic kill_req_o,
  output logic pop_o,
  output logic xlat_ex_o
);

  enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    ABORT,
    WAIT_TRANSLATION,
    WAIT_FLUSH
  } state_d, state_q;

  // a new load can only start when it has a slot to land in
  logic accept_req;
  // where to go once the cache grants, decided by the TLB lookup of that cycle
  logic gnt_to_tag;

  assign accept_req = valid_i & ~ldbuf_full_i;
  assign gnt_to_tag = dtlb_hit_i;

  // ---------------------------------------------------------------------------
  // next state and strobes
  // ---------------------------------------------------------------------------

  always_comb begin : load_control
    state_d           = state_q;
    translation_req_o = 1'b0;
    data_req_o        = 1'b0;
    tag_valid_o       = 1'b0;
    kill_req_o        = 1'b0;
    pop_o             = 1'b0;
    xlat_ex_o         = 1'b0;

    case (state_q)
      // the tag cycle of the previous load is also the index cycle of the
      // next one, which gives one load per cycle when everything hits
      IDLE, SEND_TAG: begin
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept_req) begin
          // translation starts right away, the store check runs in parallel
          translation_req_o = 1'b1;
          if (page_offset_match_i) begin
            // a pending store may overlap, hold off until it drains
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (!data_gnt_i) begin
              state_d = WAIT_GNT;
            end else if (gnt_to_tag) begin
              state_d = SEND_TAG;
              pop_o   = 1'b1;
            end else begin
              state_d = ABORT;
            end
          end
        end
      end

      // keep both requests up until the cache arbiter lets us in
      WAIT_GNT: begin
        translation_req_o = 1'b1;
        data_req_o        = 1'b1;
        if (data_gnt_i) begin
          if (gnt_to_tag) begin
            state_d = SEND_TAG;
            pop_o   = 1'b1;
          end else begin
            state_d = ABORT;
          end
        end
      end

      // retry as soon as no store shares the page offset any more
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_match_i) begin
          state_d = WAIT_GNT;
        end
      end

      // the cache already holds our index but there is no tag to give it,
      // so release the cache and let the page table walker fill the TLB
      ABORT: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = WAIT_TRANSLATION;
      end

      WAIT_TRANSLATION: begin
        translation_req_o = 1'b1;
        if (dtlb_hit_i) begin
          state_d = WAIT_GNT;
        end
        // a faulting translation retires the load with an exception, but a
        // response in the same cycle owns the result port, so the load stays
        // put and goes around again from idle
        if (ex_valid_i) begin
          state_d   = IDLE;
          pop_o     = ~data_rvalid_i;
          xlat_ex_o = ~data_rvalid_i & valid_i;
        end
      end

      // tell the cache that whatever request was open is dead
      WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: state_d = IDLE;
    endcase

    // a flush wins over every other transition
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- verilog/load_buffer.sv
// Table of loads waiting for cache data, instantiated by the load unit and indexed by request id
module load_buffer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  logic                                write_i,
  input  load_pkg::ldbuf_entry_t              wdata_i,
  input  logic                                read_i,
  input  logic [load_pkg::LDBUF_IDX_W-1:0]    rindex_i,
  output logic [load_pkg::LDBUF_IDX_W-1:0]    windex_o,
  output logic                                full_o,
  output load_pkg::ldbuf_entry_t              rdata_o,
  output logic                                rflushed_o,
  output logic [load_pkg::LDBUF_IDX_W-1:0]    last_id_o
);

  // a slot is valid from its grant until its response
  logic [load_pkg::LDBUF_ENTRIES-1:0] valid_d, valid_q;
  // flushed slots still wait for their response but must not retire
  logic [load_pkg::LDBUF_ENTRIES-1:0] flushed_d, flushed_q;
  load_pkg::ldbuf_entry_t             entries_q [load_pkg::LDBUF_ENTRIES];
  logic [load_pkg::LDBUF_IDX_W-1:0]   free_idx;
  logic [load_pkg::LDBUF_IDX_W-1:0]   last_id_q;

  // ---------------------------------------------------------------------------
  // free slot search
  // ---------------------------------------------------------------------------

  // walk from the top down so the lowest free slot is the one left standing
  always_comb begin : free_search
    free_idx = '0;
    for (int i = load_pkg::LDBUF_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = i[load_pkg::LDBUF_IDX_W-1:0];
      end
    end
  end

  assign windex_o = free_idx;
  assign full_o   = &valid_q;

  // ---------------------------------------------------------------------------
  // slot bookkeeping
  // ---------------------------------------------------------------------------

  always_comb begin : slot_update
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // every load in flight at a flush belongs to the squashed path
    if (flush_i) begin
      flushed_d = '1;
    end
    // the response frees its slot in the cycle it arrives
    if (read_i) begin
      valid_d[rindex_i] = 1'b0;
    end
    // a fresh grant is never flushed, even when it shares the cycle with one
    if (write_i) begin
      valid_d[free_idx]   = 1'b1;
      flushed_d[free_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      // remember the newest slot, its response may still be killed
      if (write_i) begin
        last_id_q <= free_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin : entry_regs
    if (write_i) begin
      entries_q[free_idx] <= wdata_i;
    end
  end

  assign rdata_o    = entries_q[rindex_i];
  assign rflushed_o = flushed_q[rindex_i];
  assign last_id_o  = last_id_q;

endmodule

//--- verilog/load_result_align.sv
// Result formatter, instantiated by the load unit to realign and extend the returned data word
module load_result_align (
  input  mem_port_pkg::rdata_u              rdata_i,
  input  load_pkg::ldbuf_entry_t            entry_i,
  output logic [mem_port_pkg::XLEN-1:0]     result_o
);

  logic [mem_port_pkg::XLEN-1:0]       shifted;
  // top bit of every byte lane, one of them is the sign of the loaded value
  logic [mem_port_pkg::BYTE_LANES-1:0] lane_msb;
  logic [load_pkg::OFFSET_W-1:0]       sign_lane;
  logic                                is_signed;
  logic                                sign_bit;

  // move the addressed byte down to lane zero
  assign shifted = rdata_i.word >> {entry_i.offset, 3'b000};

  for (genvar i = 0; i < mem_port_pkg::BYTE_LANES; i++) begin : gen_lane_msb
    assign lane_msb[i] = rdata_i.lanes[i][7];
  end

  // ---------------------------------------------------------------------------
  // sign selection
  // ---------------------------------------------------------------------------

  // the sign sits in the highest byte of the access, found from the unshifted
  // word so it does not wait for the shifter
  always_comb begin : sign_select
    case (entry_i.op)
      load_pkg::LW, load_pkg::LWU: sign_lane = entry_i.offset + 3'd3;
      load_pkg::LH, load_pkg::LHU: sign_lane = entry_i.offset + 3'd1;
      default:                     sign_lane = entry_i.offset;
    endcase
  end

  assign is_signed = entry_i.op inside {load_pkg::LW, load_pkg::LH, load_pkg::LB};
  // unsigned loads fill with zeros
  assign sign_bit  = is_signed & lane_msb[sign_lane];

  // ---------------------------------------------------------------------------
  // extension
  // ---------------------------------------------------------------------------

  always_comb begin : extend
    case (entry_i.op)
      load_pkg::LW, load_pkg::LWU:
        result_o = {{(mem_port_pkg::XLEN - 32){sign_bit}}, shifted[31:0]};
      load_pkg::LH, load_pkg::LHU:
        result_o = {{(mem_port_pkg::XLEN - 16){sign_bit}}, shifted[15:0]};
      load_pkg::LB, load_pkg::LBU:
        result_o = {{(mem_port_pkg::XLEN - 8){sign_bit}}, shifted[7:0]};
      // a doubleword is already aligned, nothing to extend
      default:
        result_o = shifted;
    endcase
  end

endmodule

//--- verilog/load_unit.sv
// Load stage of the load/store unit, the top level seen by issue, MMU, store checker and data cache
module load_unit (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // issue side
  input  logic                                 valid_i,
  input  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_i,
  input  logic [mem_port_pkg::VLEN-1:0]        vaddr_i,
  input  load_pkg::load_op_e                   op_i,
  input  logic [mem_port_pkg::BYTE_LANES-1:0]  be_i,
  output logic                                 pop_o,
  // result side
  output logic                                 valid_o,
  output logic [load_pkg::TRANS_ID_W-1:0]      trans_id_o,
  output logic [mem_port_pkg::XLEN-1:0]        result_o,
  output logic                                 ex_valid_o,
  // MMU
  output logic                                 translation_req_o,
  output logic [mem_port_pkg::VLEN-1:0]        vaddr_o,
  input  logic [mem_port_pkg::PLEN-1:0]        paddr_i,
  input  logic                                 dtlb_hit_i,
  input  logic                                 ex_valid_i,
  // store address checker
  output logic [mem_port_pkg::INDEX_W-1:0]     page_offset_o,
  input  logic                                 page_offset_match_i,
  // data cache
  output logic                                 data_req_o,
  input  logic                                 data_gnt_i,
  output logic [mem_port_pkg::INDEX_W-1:0]     index_o,
  output logic [mem_port_pkg::TAG_W-1:0]       tag_o,
  output logic                                 tag_valid_o,
  output logic                                 kill_req_o,
  output logic [mem_port_pkg::BYTE_LANES-1:0]  data_be_o,
  output logic [1:0]                           data_size_o,
  output logic [mem_port_pkg::REQ_ID_W-1:0]    data_id_o,
  input  logic                                 data_rvalid_i,
  input  logic [mem_port_pkg::REQ_ID_W-1:0]    data_rid_i,
  input  mem_port_pkg::rdata_u                 data_rdata_i
);

  logic                               ldbuf_full;
  logic                               ldbuf_write;
  logic [load_pkg::LDBUF_IDX_W-1:0]   ldbuf_windex;
  load_pkg::ldbuf_entry_t             ldbuf_wdata;
  load_pkg::ldbuf_entry_t             ldbuf_rdata;
  logic                               ldbuf_rflushed;
  logic [load_pkg::LDBUF_IDX_W-1:0]   ldbuf_last_id;
  logic                               xlat_ex;

  // ---------------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------------

  // the page offset is untranslated, so it feeds the index and the store check
  assign vaddr_o       = vaddr_i;
  assign page_offset_o = vaddr_i[mem_port_pkg::INDEX_W-1:0];
  assign index_o       = vaddr_i[mem_port_pkg::INDEX_W-1:0];
  // the translation of the previous cycle supplies the tag
  assign tag_o         = paddr_i[mem_port_pkg::PLEN-1:mem_port_pkg::INDEX_W];
  assign data_be_o     = be_i;
  assign data_size_o   = load_pkg::size_of(op_i);
  // the buffer slot doubles as the request id the cache echoes back
  assign data_id_o     = ldbuf_windex;

  // a granted request is the moment the load becomes outstanding
  assign ldbuf_write = data_req_o & data_gnt_i;
  assign ldbuf_wdata = '{trans_id: trans_id_i,
                         offset:   vaddr_i[load_pkg::OFFSET_W-1:0],
                         op:       op_i};

  load_ctrl_fsm u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .valid_i             (valid_i),
    .ldbuf_full_i        (ldbuf_full),
    .page_offset_match_i (page_offset_match_i),
    .data_gnt_i          (data_gnt_i),
    .dtlb_hit_i          (dtlb_hit_i),
    .ex_valid_i          (ex_valid_i),
    .data_rvalid_i       (data_rvalid_i),
    .translation_req_o   (translation_req_o),
    .data_req_o          (data_req_o),
    .tag_valid_o         (tag_valid_o),
    .kill_req_o          (kill_req_o),
    .pop_o               (pop_o),
    .xlat_ex_o           (xlat_ex)
  );

  load_buffer u_ldbuf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .write_i    (ldbuf_write),
    .wdata_i    (ldbuf_wdata),
    .read_i     (data_rvalid_i),
    .rindex_i   (data_rid_i),
    .windex_o   (ldbuf_windex),
    .full_o     (ldbuf_full),
    .rdata_o    (ldbuf_rdata),
    .rflushed_o (ldbuf_rflushed),
    .last_id_o  (ldbuf_last_id)
  );

  // ---------------------------------------------------------------------------
  // response side
  // ---------------------------------------------------------------------------

  load_result_align u_align (
    .rdata_i  (data_rdata_i),
    .entry_i  (ldbuf_rdata),
    .result_o (result_o)
  );

  always_comb begin : retire
    valid_o    = 1'b0;
    ex_valid_o = 1'b0;
    trans_id_o = ldbuf_rdata.trans_id;
    // a response of a squashed load is swallowed, and so is the newest
    // load's response while its request is being killed
    if (data_rvalid_i && !ldbuf_rflushed) begin
      if ((ldbuf_last_id != data_rid_i) || !kill_req_o) begin
        valid_o = 1'b1;
      end
    end
    // translation faults retire the load still sitting at the issue port,
    // the FSM only raises this when no response competes for the port
    if (xlat_ex) begin
      valid_o    = 1'b1;
      ex_valid_o = 1'b1;
      trans_id_o = trans_id_i;
    end
  end

endmodule

//--- testbench/tb_load_unit.sv
// Directed testbench for the load unit with data cache and MMU models around the DUT
module tb_load_unit;
  timeunit 1ns;
  timeprecision 100ps;

  // all tests together run a few hundred cycles, so this only trips on a hang
  localparam int TIMEOUT_CYCLES = 3000;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 flush_i;
  logic                                 valid_i;
  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_i;
  logic [mem_port_pkg::VLEN-1:0]        vaddr_i;
  load_pkg::load_op_e                   op_i;
  logic [7:0]                           be_i;
  logic                                 pop_o;
  logic                                 valid_o;
  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_o;
  logic [mem_port_pkg::XLEN-1:0]        result_o;
  logic                                 ex_valid_o;
  logic                                 translation_req_o;
  logic [mem_port_pkg::VLEN-1:0]        vaddr_o;
  logic [mem_port_pkg::PLEN-1:0]        paddr_i = '0;
  logic                                 dtlb_hit_i;
  logic                                 ex_valid_i;
  logic [mem_port_pkg::INDEX_W-1:0]     page_offset_o;
  logic                                 page_offset_match_i;
  logic                                 data_req_o;
  logic                                 data_gnt_i;
  logic [mem_port_pkg::INDEX_W-1:0]     index_o;
  logic [mem_port_pkg::TAG_W-1:0]       tag_o;
  logic                                 tag_valid_o;
  logic                                 kill_req_o;
  logic [7:0]                           data_be_o;
  logic [1:0]                           data_size_o;
  logic [mem_port_pkg::REQ_ID_W-1:0]    data_id_o;
  logic                                 data_rvalid_i;
  logic [mem_port_pkg::REQ_ID_W-1:0]    data_rid_i;
  mem_port_pkg::rdata_u                 data_rdata_i;

  integer                               seed = 32'h9231;
  int                                   errors = 0;
  int                                   checks = 0;
  int                                   cycles = 0;
  logic [load_pkg::TRANS_ID_W-1:0]      next_tid = '0;
  // what the cache model remembers about each granted request id
  logic [load_pkg::TRANS_ID_W-1:0]      exp_tid [4];
  logic [2:0]                           exp_off [4];
  load_pkg::load_op_e                   exp_op  [4];

  load_unit dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // the MMU model answers with the translation of the previous cycle's address
  always @(posedge clk_i) begin
    paddr_i <= map_paddr(vaddr_i);
  end

  // every granted request is recorded under the id the cache will echo
  always @(negedge clk_i) begin
    if (data_req_o && data_gnt_i) begin
      exp_tid[data_id_o] = trans_id_i;
      exp_off[data_id_o] = vaddr_i[2:0];
      exp_op[data_id_o]  = op_i;
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // reference model and helpers
  // ------------------------------------------------------------------------

  function automatic logic [55:0] map_paddr(logic [38:0] va);
    return {17'h0a5c3, va[38:12] ^ 27'h2b3c4d5, va[11:0]};
  endfunction

  // the cache tag is everything above the page offset of the physical address
  function automatic logic [43:0] tag_of(logic [38:0] va);
    logic [55:0] pa;
    pa = map_paddr(va);
    return pa[55:12];
  endfunction

  function automatic int bytes_of(load_pkg::load_op_e op);
    case (op)
      load_pkg::LD: return 8;
      load_pkg::LW, load_pkg::LWU: return 4;
      load_pkg::LH, load_pkg::LHU: return 2;
      default: return 1;
    endcase
  endfunction

  function automatic logic [7:0] be_of(load_pkg::load_op_e op, logic [2:0] off);
    logic [7:0] m;
    for (int i = 0; i < 8; i++) begin
      m[i] = (i >= int'(off)) && (i < int'(off) + bytes_of(op));
    end
    return m;
  endfunction

  // take the addressed bytes and fill above them with the sign or with zeros
  function automatic logic [63:0] ref_result(logic [63:0] word, logic [2:0] off,
                                             load_pkg::load_op_e op);
    int         base;
    int         width;
    logic       sign;
    logic [63:0] r;
    base  = 8 * int'(off);
    width = 8 * bytes_of(op);
    sign  = 1'b0;
    if (op == load_pkg::LW || op == load_pkg::LH || op == load_pkg::LB) begin
      sign = word[base + width - 1];
    end
    for (int b = 0; b < 64; b++) begin
      if (b < width) begin
        r[b] = word[base + b];
      end else begin
        r[b] = sign;
      end
    end
    return r;
  endfunction

  task automatic expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("error at %0d ns: %s", $time, msg);
    end
  endtask

  // the cache and MMU see the untranslated address, the byte lanes and the size
  task automatic check_request(input logic [38:0] va, input load_pkg::load_op_e op,
                               input logic [2:0] off);
    expect_true(vaddr_o == va, $sformatf("vaddr %h, expected %h", vaddr_o, va));
    expect_true(index_o == va[11:0] && page_offset_o == va[11:0],
                $sformatf("index %h or page offset %h, expected %h",
                          index_o, page_offset_o, va[11:0]));
    expect_true(data_be_o == be_of(op, off),
                $sformatf("byte enables %b, expected %b", data_be_o, be_of(op, off)));
    expect_true(data_size_o == 2'($clog2(bytes_of(op))),
                $sformatf("size %0d is wrong for %0d bytes", data_size_o, bytes_of(op)));
  endtask

  // puts a fresh load on the issue port, called right after a rising edge
  task automatic drive_load(input load_pkg::load_op_e op, input logic [2:0] off,
                            output logic [38:0] va);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    va = {r[38:3], off};
    valid_i    <= 1'b1;
    trans_id_i <= next_tid;
    vaddr_i    <= va;
    op_i       <= op;
    be_i       <= be_of(op, off);
    next_tid   = next_tid + 3'd1;
  endtask

  // issues one load that hits, with a grant delay and a store-offset stall
  task automatic issue_load(input load_pkg::load_op_e op, input logic [2:0] off,
                            input int gnt_delay, input int match_cycles,
                            output logic [1:0] id);
    logic [38:0] va;
    int          k;
    int          reqs;
    bit          started;
    bit          popped;
    k = 0;
    reqs = 0;
    started = 0;
    popped = 0;
    while (!popped) begin
      @(posedge clk_i);
      if (k == 0) begin
        drive_load(op, off, va);
      end
      page_offset_match_i <= (k < match_cycles);
      data_gnt_i          <= (reqs >= gnt_delay);
      @(negedge clk_i);
      if (page_offset_match_i) begin
        expect_true(!data_req_o, "cache request while the page offset matches");
      end
      if (started && !data_gnt_i) begin
        expect_true(data_req_o, "cache request dropped before its grant");
      end
      expect_true(!tag_valid_o, "tag sent before the grant");
      if (data_req_o) begin
        started = 1;
        reqs++;
      end
      if (pop_o) begin
        popped = 1;
        id = data_id_o;
        check_request(va, op, off);
      end
      k++;
    end
    expect_true(reqs == gnt_delay + 1, $sformatf("%0d request cycles, expected %0d",
                                                 reqs, gnt_delay + 1));
    @(posedge clk_i);
    valid_i    <= 1'b0;
    data_gnt_i <= 1'b0;
    @(negedge clk_i);
    expect_true(tag_valid_o && !kill_req_o, "no tag in the cycle after the grant");
    expect_true(tag_o == tag_of(va), $sformatf("tag %h is wrong", tag_o));
  endtask

  // one cache response with random data, expected to retire or to be dropped
  task automatic respond(input logic [1:0] id, input bit retire);
    logic [63:0] w;
    logic [63:0] exp;
    w = {$random(seed), $random(seed)};
    @(posedge clk_i);
    data_rvalid_i     <= 1'b1;
    data_rid_i        <= id;
    data_rdata_i.word <= w;
    @(negedge clk_i);
    if (retire) begin
      exp = ref_result(w, exp_off[id], exp_op[id]);
      expect_true(valid_o && !ex_valid_o, $sformatf("no result for request id %0d", id));
      expect_true(trans_id_o == exp_tid[id], $sformatf("trans id %0d, expected %0d",
                                                       trans_id_o, exp_tid[id]));
      expect_true(result_o == exp, $sformatf("result %h, expected %h", result_o, exp));
    end else begin
      expect_true(!valid_o, $sformatf("dropped response of id %0d retired", id));
    end
    @(posedge clk_i);
    data_rvalid_i <= 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------

  // every operation at every aligned offset, answered four at a time backwards
  task automatic hits_all_ops();
    load_pkg::load_op_e op;
    logic [1:0]         id;
    logic [1:0]         batch[$];
    for (int o = 0; o < 7; o++) begin
      op = load_pkg::load_op_e'(3'(o));
      for (int off = 0; off < 8; off += bytes_of(op)) begin
        issue_load(op, 3'(off), 0, 0, id);
        batch.push_back(id);
        if (batch.size() == 4) begin
          while (batch.size() > 0) begin
            respond(batch.pop_back(), 1'b1);
          end
        end
      end
    end
    while (batch.size() > 0) begin
      respond(batch.pop_back(), 1'b1);
    end
  endtask

  task automatic grant_delay();
    logic [1:0] id;
    issue_load(load_pkg::LD, 3'd0, 3, 0, id);
    respond(id, 1'b1);
  endtask

  task automatic offset_stall();
    logic [1:0] id;
    issue_load(load_pkg::LHU, 3'd6, 0, 3, id);
    respond(id, 1'b1);
  endtask

  // a miss at the grant aborts the request, then a hit or a fault follows
  task automatic tlb_miss_retry(input bit fault);
    logic [38:0] va;
    logic [1:0]  id;
    @(posedge clk_i);
    drive_load(load_pkg::LW, 3'd4, va);
    dtlb_hit_i <= 1'b0;
    data_gnt_i <= 1'b1;
    @(negedge clk_i);
    expect_true(data_req_o && !pop_o, "missed load was popped at its grant");
    id = data_id_o;
    // the cache answers the killed request in the abort cycle
    @(posedge clk_i);
    data_gnt_i        <= 1'b0;
    data_rvalid_i     <= 1'b1;
    data_rid_i        <= id;
    data_rdata_i.word <= {$random(seed), $random(seed)};
    @(negedge clk_i);
    expect_true(kill_req_o && tag_valid_o, "no kill one cycle after the missed grant");
    expect_true(!valid_o, "response of the killed request retired");
    @(posedge clk_i);
    data_rvalid_i <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      expect_true(translation_req_o && !data_req_o, "translation request not held");
      @(posedge clk_i);
    end
    if (fault) begin
      ex_valid_i <= 1'b1;
      @(negedge clk_i);
      expect_true(valid_o && ex_valid_o && pop_o, "translation fault not reported");
      expect_true(trans_id_o == trans_id_i, "fault carries the wrong trans id");
      @(posedge clk_i);
      ex_valid_i <= 1'b0;
      valid_i    <= 1'b0;
      dtlb_hit_i <= 1'b1;
      @(negedge clk_i);
      expect_true(!valid_o && !translation_req_o, "translation fault retired more than once");
    end else begin
      dtlb_hit_i <= 1'b1;
      @(negedge clk_i);
      expect_true(translation_req_o && !data_req_o, "translation request dropped early");
      @(posedge clk_i);
      data_gnt_i <= 1'b1;
      @(negedge clk_i);
      expect_true(data_req_o && pop_o, "load not reissued after the TLB hit");
      id = data_id_o;
      check_request(va, load_pkg::LW, 3'd4);
      @(posedge clk_i);
      valid_i    <= 1'b0;
      data_gnt_i <= 1'b0;
      @(negedge clk_i);
      expect_true(tag_valid_o && !kill_req_o, "no tag after the reissued grant");
      expect_true(tag_o == tag_of(va), $sformatf("reissued tag %h is wrong", tag_o));
      respond(id, 1'b1);
    end
  endtask

  task automatic flush_outstanding();
    logic [1:0] id_a;
    logic [1:0] id_b;
    logic [1:0] id_c;
    issue_load(load_pkg::LB, 3'd3, 0, 0, id_a);
    issue_load(load_pkg::LD, 3'd0, 0, 0, id_b);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    expect_true(kill_req_o && tag_valid_o, "no kill in the cycle after the flush");
    issue_load(load_pkg::LWU, 3'd0, 0, 0, id_c);
    respond(id_a, 1'b0);
    respond(id_b, 1'b0);
    respond(id_c, 1'b1);
  endtask

  // a fifth load must wait for a free buffer entry
  task automatic buffer_full_stall();
    logic [38:0] va;
    logic [1:0]  id;
    logic [1:0]  ids[$];
    for (int i = 0; i < 4; i++) begin
      issue_load(load_pkg::LH, 3'd2, 0, 0, id);
      ids.push_back(id);
    end
    @(posedge clk_i);
    drive_load(load_pkg::LBU, 3'd5, va);
    data_gnt_i <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      expect_true(!pop_o && !data_req_o, "load accepted with a full buffer");
      if (i < 3) begin
        @(posedge clk_i);
      end
    end
    respond(ids[1], 1'b1);
    @(negedge clk_i);
    expect_true(pop_o && data_id_o == ids[1], "load not accepted into the freed entry");
    id = data_id_o;
    check_request(va, load_pkg::LBU, 3'd5);
    @(posedge clk_i);
    valid_i    <= 1'b0;
    data_gnt_i <= 1'b0;
    @(negedge clk_i);
    expect_true(tag_valid_o, "no tag for the stalled load");
    expect_true(tag_o == tag_of(va), $sformatf("stalled load tag %h is wrong", tag_o));
    respond(ids[0], 1'b1);
    respond(id, 1'b1);
    respond(ids[3], 1'b1);
    respond(ids[2], 1'b1);
  endtask

  initial begin
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    valid_i             = 1'b0;
    trans_id_i          = '0;
    vaddr_i             = '0;
    op_i                = load_pkg::LD;
    be_i                = '0;
    dtlb_hit_i          = 1'b1;
    ex_valid_i          = 1'b0;
    page_offset_match_i = 1'b0;
    data_gnt_i          = 1'b0;
    data_rvalid_i       = 1'b0;
    data_rid_i          = '0;
    data_rdata_i.word   = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    expect_true(!data_req_o && !pop_o && !valid_o && !tag_valid_o && !kill_req_o
                && !translation_req_o, "control outputs not low after reset");
    hits_all_ops();
    grant_delay();
    offset_stall();
    tlb_miss_retry(1'b0);
    tlb_miss_retry(1'b1);
    flush_outstanding();
    buffer_full_stall();
    repeat (2) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/mem_port_pkg.sv
verilog/load_pkg.sv
verilog/load_ctrl_fsm.sv
verilog/load_buffer.sv
verilog/load_result_align.sv
verilog/load_unit.sv
testbench/tb_load_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the load unit testbench with Verilator, runs it and judges the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_load_unit \
  -f verilog.f \
  -Mdir obj_dir

./obj_dir/Vtb_load_unit | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation passed"
